/* hw/conv_pkg.sv */
package conv_pkg;

	// one colour channel
	localparam int CH_W = 8;

	// signed width of one kernel coefficient
	localparam int COEF_W = 4;

	// signed channel sum, covers -1020..1275 for the sharpen kernel
	localparam int SUM_W = 12;

	// window to clamped result: multiply, add, clamp
	localparam int CONV_STAGES = 3;

	// rgb pixel, seen either as one raw word or as three channel bytes
	// r sits in the top byte
	typedef union packed {
		logic [3*CH_W-1:0] raw;
		struct packed {
			logic [CH_W-1:0] r;
			logic [CH_W-1:0] g;
			logic [CH_W-1:0] b;
		} ch;
	} pixel_u;

	// sharpen kernel, row-major, element 0 is top-left
	localparam logic signed [COEF_W-1:0] KERNEL [9] = '{
		4'sd0, -4'sd1, 4'sd0,
		-4'sd1, 4'sd5, -4'sd1,
		4'sd0, -4'sd1, 4'sd0
	};

endpackage

/* hw/line_tap_buffer.sv */
`timescale 1ns/100ps

module line_tap_buffer #(
	parameter int IMG_WIDTH = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_shift,
	input  conv_pkg::pixel_u i_pixel,
	output conv_pkg::pixel_u o_window [9]
);

	// one zero column on each side of the active row
	localparam int PAD_W = IMG_WIDTH + 2;

	// line_a delays by one padded row, line_b by two
	conv_pkg::pixel_u line_a [PAD_W];
	conv_pkg::pixel_u line_b [PAD_W];

	// same column in three consecutive rows
	// index 0 is the oldest row, index 2 the incoming pixel
	conv_pkg::pixel_u row_tap [3];

	// window registers per row, column 0 is the newest column
	conv_pkg::pixel_u win [3][3];

	always_comb begin
		row_tap[0] = line_b[PAD_W-1];
		row_tap[1] = line_a[PAD_W-1];
		row_tap[2] = i_pixel;
	end

	// row delay lines only move on an accepted pixel
	always_ff @(posedge clk) begin
		if (i_shift) begin
			line_a[0] <= i_pixel;
			// line_b picks up what falls out of line_a
			line_b[0] <= line_a[PAD_W-1];
			for (int k = 1; k < PAD_W; k++) begin
				line_a[k] <= line_a[k-1];
				line_b[k] <= line_b[k-1];
			end
		end
	end

	// 3x3 window, cleared so that it starts as padding
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					win[r][c] <= '0;
				end
			end
		end else if (i_shift) begin
			for (int r = 0; r < 3; r++) begin
				win[r][0] <= row_tap[r];
				win[r][1] <= win[r][0];
				win[r][2] <= win[r][1];
			end
		end
	end

	// row-major output, element 0 is oldest row and oldest column
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				o_window[3*r + c] = win[r][2-c];
			end
		end
	end

endmodule

/* hw/channel_conv_3x3.sv */
`timescale 1ns/100ps

module channel_conv_3x3 (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      i_evt,
	input  logic [conv_pkg::CH_W-1:0] i_taps [9],
	output logic                      o_evt,
	output logic [conv_pkg::CH_W-1:0] o_value
);

	localparam int CW = conv_pkg::CH_W;
	localparam int SW = conv_pkg::SUM_W;
	localparam int NS = conv_pkg::CONV_STAGES;
	localparam int MAX_VAL = (1 << CW) - 1;

	// taps and coefficients widened to the signed sum width
	logic signed [SW-1:0] tap_x  [9];
	logic signed [SW-1:0] coef_x [9];
	logic signed [SW-1:0] prod_q [9];
	logic signed [SW-1:0] sum_d;
	logic signed [SW-1:0] sum_q;
	// event bit travelling beside the data
	logic [NS-1:0] evt_q;

	always_comb begin
		for (int k = 0; k < 9; k++) begin
			// taps are unsigned, zero fill on top
			tap_x[k] = {{(SW-CW){1'b0}}, i_taps[k]};
			// coefficients sign-extend through the size cast
			coef_x[k] = SW'(conv_pkg::KERNEL[k]);
		end
	end

	// stage 1, products fit SW bits since |tap*coef| <= 255*8
	always_ff @(posedge clk) begin
		for (int k = 0; k < 9; k++) begin
			prod_q[k] <= tap_x[k] * coef_x[k];
		end
	end

	// stage 2, nine-way sum
	always_comb begin
		sum_d = '0;
		for (int k = 0; k < 9; k++) begin
			sum_d = sum_d + prod_q[k];
		end
	end

	always_ff @(posedge clk) begin
		sum_q <= sum_d;
	end

	// stage 3, saturate to the channel range
	always_ff @(posedge clk) begin
		if (sum_q < 0) begin
			o_value <= '0;
		end else if (sum_q > MAX_VAL) begin
			o_value <= '1;
		end else begin
			o_value <= sum_q[CW-1:0];
		end
	end

	// data stages run every cycle, only the event bit says which result counts
	always_ff @(posedge clk) begin
		if (reset) begin
			evt_q <= '0;
		end else begin
			evt_q <= {evt_q[NS-2:0], i_evt};
		end
	end

	assign o_evt = evt_q[NS-1];

	// each result event lines up with a window event NS cycles back
	a_evt_latency: assert property (@(posedge clk) disable iff (reset)
		o_evt == ($past(i_evt, NS) && !$past(reset, NS)))
		else $error("convolver event out of step with its window");

endmodule

/* hw/pixel_filter.sv */
`timescale 1ns/100ps

module pixel_filter #(
	parameter int IMG_WIDTH  = 8,
	parameter int IMG_HEIGHT = 6
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_valid,
	input  conv_pkg::pixel_u i_pixel,
	output logic             o_evt,
	output logic             o_keep,
	output logic             o_last,
	output conv_pkg::pixel_u o_pixel
);

	localparam int CW = conv_pkg::CH_W;
	localparam int NS = conv_pkg::CONV_STAGES;
	// the source sends frames with a one pixel zero ring
	localparam int PAD_W = IMG_WIDTH + 2;
	localparam int PAD_H = IMG_HEIGHT + 2;
	localparam int COL_W = $clog2(PAD_W);
	localparam int ROW_W = $clog2(PAD_H);

	logic             r_valid;
	conv_pkg::pixel_u r_pixel;
	// padded position of r_pixel
	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;
	logic             cur_keep;
	logic             cur_last;
	// window stage flags
	logic             win_evt;
	logic             win_keep;
	logic             win_last;
	conv_pkg::pixel_u window [9];
	logic [CW-1:0]    r_taps [9];
	logic [CW-1:0]    g_taps [9];
	logic [CW-1:0]    b_taps [9];
	logic             r_evt;
	logic             g_evt;
	logic             b_evt;
	logic [CW-1:0]    r_value;
	logic [CW-1:0]    g_value;
	logic [CW-1:0]    b_value;
	// keep and last delayed to meet the convolver results
	logic [NS-1:0]    keep_q;
	logic [NS-1:0]    last_q;

	// input register, cycle 1
	always_ff @(posedge clk) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= i_valid;
		end
	end

	always_ff @(posedge clk) begin
		r_pixel <= i_pixel;
	end

	// raster position in the padded frame, wraps at frame end
	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (r_valid) begin
			if (col_cnt == COL_W'(PAD_W - 1)) begin
				col_cnt <= '0;
				if (row_cnt == ROW_W'(PAD_H - 1)) begin
					row_cnt <= '0;
				end else begin
					row_cnt <= row_cnt + 1'b1;
				end
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// the window ending at (row, col) is centred on (row-1, col-1)
	// which is active only from the third row and third column on
	assign cur_keep = (row_cnt >= ROW_W'(2)) && (row_cnt <= ROW_W'(IMG_HEIGHT + 1))
		&& (col_cnt >= COL_W'(2)) && (col_cnt <= COL_W'(IMG_WIDTH + 1));
	assign cur_last = (row_cnt == ROW_W'(IMG_HEIGHT + 1))
		&& (col_cnt == COL_W'(IMG_WIDTH + 1));

	// flags enter the window stage together with the pixel, cycle 2
	always_ff @(posedge clk) begin
		if (reset) begin
			win_evt  <= 1'b0;
			win_keep <= 1'b0;
			win_last <= 1'b0;
		end else begin
			win_evt  <= r_valid;
			win_keep <= r_valid & cur_keep;
			win_last <= r_valid & cur_last;
		end
	end

	line_tap_buffer #(
		.IMG_WIDTH(IMG_WIDTH)
	) u_line_buf (
		.clk     (clk),
		.reset   (reset),
		.i_shift (r_valid),
		.i_pixel (r_pixel),
		.o_window(window)
	);

	// split window into colour planes
	always_comb begin
		for (int k = 0; k < 9; k++) begin
			r_taps[k] = window[k].ch.r;
			g_taps[k] = window[k].ch.g;
			b_taps[k] = window[k].ch.b;
		end
	end

	channel_conv_3x3 r_conv (
		.clk(clk), .reset(reset), .i_evt(win_evt), .i_taps(r_taps),
		.o_evt(r_evt), .o_value(r_value)
	);

	channel_conv_3x3 g_conv (
		.clk(clk), .reset(reset), .i_evt(win_evt), .i_taps(g_taps),
		.o_evt(g_evt), .o_value(g_value)
	);

	channel_conv_3x3 b_conv (
		.clk(clk), .reset(reset), .i_evt(win_evt), .i_taps(b_taps),
		.o_evt(b_evt), .o_value(b_value)
	);

	// flag pipeline runs freely like the convolver stages
	always_ff @(posedge clk) begin
		if (reset) begin
			keep_q <= '0;
			last_q <= '0;
		end else begin
			keep_q <= {keep_q[NS-2:0], win_keep};
			last_q <= {last_q[NS-2:0], win_last};
		end
	end

	// all three channels step together, cycle 5 after input
	assign o_evt  = r_evt & g_evt & b_evt;
	assign o_keep = keep_q[NS-1];
	assign o_last = last_q[NS-1];

	always_comb begin
		o_pixel.ch.r = r_value;
		o_pixel.ch.g = g_value;
		o_pixel.ch.b = b_value;
	end

	a_col_range: assert property (@(posedge clk) disable iff (reset)
		col_cnt < COL_W'(PAD_W))
		else $error("column counter left the padded row");

endmodule

/* hw/credit_out_fifo.sv */
`timescale 1ns/100ps

module credit_out_fifo #(
	parameter int FIFO_DEPTH   = 16,
	parameter int DOWN_CREDITS = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_evt,
	input  logic             i_keep,
	input  logic             i_last,
	input  conv_pkg::pixel_u i_pixel,
	output logic [1:0]       o_credit_ret,
	output logic             o_valid,
	output conv_pkg::pixel_u o_pixel,
	output logic             o_last,
	input  logic             i_credit
);

	localparam int PIX_W = $bits(conv_pkg::pixel_u);
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int DCR_W = $clog2(DOWN_CREDITS + 1);

	logic [PIX_W-1:0] mem_pix  [FIFO_DEPTH];
	logic             mem_last [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	// credits granted by the consumer and not yet spent
	logic [DCR_W-1:0] down_cnt;
	logic             wr_en;
	logic             drop;
	logic             pop;

	assign wr_en = i_evt & i_keep;
	// border windows never reach the queue
	assign drop  = i_evt & ~i_keep;
	assign pop   = (count != '0) && (down_cnt != '0);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_pix[wr_ptr]  <= i_pixel.raw;
			mem_last[wr_ptr] <= i_last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// spend one credit per output, regain one per i_credit pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			down_cnt <= DCR_W'(DOWN_CREDITS);
		end else begin
			case ({pop, i_credit})
				2'b10:   down_cnt <= down_cnt - 1'b1;
				2'b01:   down_cnt <= down_cnt + 1'b1;
				default: down_cnt <= down_cnt;
			endcase
		end
	end

	assign o_valid     = pop;
	assign o_pixel.raw = mem_pix[rd_ptr];
	assign o_last      = mem_last[rd_ptr];

	// a dropped window and a departing pixel may both free a slot
	assign o_credit_ret = {1'b0, drop} + {1'b0, pop};

	// upstream holds at most FIFO_DEPTH credits, so a full queue sees no write
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (count < CNT_W'(FIFO_DEPTH)))
		else $error("write into a full output queue");

	// consumer returns no more credits than it was given
	a_down_bound: assert property (@(posedge clk) disable iff (reset)
		down_cnt <= DCR_W'(DOWN_CREDITS))
		else $error("downstream credit counter above its start value");

	// credits must cover the trip through register, window and convolver
	a_depth: assert property (@(posedge clk)
		FIFO_DEPTH > conv_pkg::CONV_STAGES + 2)
		else $error("output queue too shallow for the filter pipeline");

endmodule

/* hw/filter_top.sv */
`timescale 1ns/100ps

module filter_top #(
	parameter int IMG_WIDTH    = 8,
	parameter int IMG_HEIGHT   = 6,
	parameter int FIFO_DEPTH   = 16,
	parameter int DOWN_CREDITS = 4
) (
	input  logic             clk,
	input  logic             reset,
	// upstream, one pixel per credit held by the source
	input  logic             i_valid,
	input  conv_pkg::pixel_u i_pixel,
	output logic [1:0]       o_credit_ret,
	// downstream, one output per credit granted by the consumer
	output logic             o_valid,
	output conv_pkg::pixel_u o_pixel,
	output logic             o_last,
	input  logic             i_credit
);

	// window events from the filter
	logic             filt_evt;
	logic             filt_keep;
	logic             filt_last;
	conv_pkg::pixel_u filt_pixel;

	// every accepted pixel yields one event, kept or dropped
	pixel_filter #(
		.IMG_WIDTH (IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT)
	) u_pixel_filter (
		.clk    (clk),
		.reset  (reset),
		.i_valid(i_valid),
		.i_pixel(i_pixel),
		.o_evt  (filt_evt),
		.o_keep (filt_keep),
		.o_last (filt_last),
		.o_pixel(filt_pixel)
	);

	// queue turns events back into upstream credits
	credit_out_fifo #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.DOWN_CREDITS(DOWN_CREDITS)
	) u_credit_out_fifo (
		.clk         (clk),
		.reset       (reset),
		.i_evt       (filt_evt),
		.i_keep      (filt_keep),
		.i_last      (filt_last),
		.i_pixel     (filt_pixel),
		.o_credit_ret(o_credit_ret),
		.o_valid     (o_valid),
		.o_pixel     (o_pixel),
		.o_last      (o_last),
		.i_credit    (i_credit)
	);

endmodule

/* dv/filter_model.svh */
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

// source pixel for padded position (row, col)
// the outer ring is the zero padding the filter expects
function automatic conv_pkg::pixel_u make_pixel(int row, int col);
	conv_pkg::pixel_u p;
	int pick;
	p.raw = '0;
	if (row == 0 || row == PAD_H - 1 || col == 0 || col == PAD_W - 1) begin
		return p;
	end
	pick = int'($urandom % 8);
	if (pick == 0) begin
		// dark spot, its neighbours drive the sum below zero
		p.raw = '0;
	end else if (pick == 1) begin
		// bright spot, centre weight 5 pushes the sum past 255
		p.raw = '1;
	end else begin
		p.raw = 24'($urandom);
	end
	return p;
endfunction

// saturate a channel sum to one byte
function automatic int clamp_byte(int sum);
	if (sum < 0) begin
		return 0;
	end
	if (sum > 255) begin
		return 255;
	end
	return sum;
endfunction

// kernel over the 3x3 padded neighbourhood of active pixel (y, x)
// ch 0 is red, 1 green, 2 blue
function automatic int channel_sum(int f, int y, int x, int ch);
	conv_pkg::pixel_u p;
	int acc;
	int tap;
	int coef;
	acc = 0;
	for (int dr = 0; dr < 3; dr++) begin
		for (int dc = 0; dc < 3; dc++) begin
			// active (y, x) sits at padded (y+1, x+1)
			p = frames[f][y + dr][x + dc];
			tap = (ch == 0) ? int'(p.ch.r) : (ch == 1) ? int'(p.ch.g) : int'(p.ch.b);
			coef = int'(conv_pkg::KERNEL[3*dr + dc]);
			acc = acc + tap * coef;
		end
	end
	return acc;
endfunction

// expected filtered pixel, all three channels clamped
function automatic conv_pkg::pixel_u expected_pixel(int f, int y, int x);
	conv_pkg::pixel_u e;
	e.ch.r = 8'(clamp_byte(channel_sum(f, y, x, 0)));
	e.ch.g = 8'(clamp_byte(channel_sum(f, y, x, 1)));
	e.ch.b = 8'(clamp_byte(channel_sum(f, y, x, 2)));
	return e;
endfunction

`endif

/* dv/tb_filter_top.sv */
`timescale 1ns/100ps

module tb_filter_top;

	localparam int IMG_WIDTH = 8;
	localparam int IMG_HEIGHT = 6;
	localparam int FIFO_DEPTH = 16;
	localparam int DOWN_CREDITS = 4;
	localparam int PAD_W = IMG_WIDTH + 2;
	localparam int PAD_H = IMG_HEIGHT + 2;
	localparam int NUM_FRAMES = 3;
	localparam int FRAME_PIX = IMG_WIDTH * IMG_HEIGHT;
	localparam int TOTAL_OUT = NUM_FRAMES * FRAME_PIX;
	localparam int STALL_CYCLES = 300;
	localparam int CREDIT_WAIT_LIMIT = 1000;
	localparam int DRAIN_LIMIT = 5000;

	logic clk = 1'b0;
	logic reset;
	logic i_valid;
	conv_pkg::pixel_u i_pixel;
	logic [1:0] o_credit_ret;
	logic o_valid;
	conv_pkg::pixel_u o_pixel;
	logic o_last;
	logic i_credit = 1'b0;

	// padded source frames and the expected output stream
	conv_pkg::pixel_u frames [NUM_FRAMES][PAD_H][PAD_W];
	conv_pkg::pixel_u exp_pix [TOTAL_OUT];
	bit exp_last [TOTAL_OUT];

	// upstream credit bookkeeping with one writer each
	int credits_sent = 0;
	int credits_back = 0;
	bit started = 1'b0;
	// downstream side
	int out_count = 0;
	int credit_pulses = 0;
	int credits_given = 0;
	int stall_cnt = 0;
	bit stall_armed = 1'b0;

	`include "filter_model.svh"

	filter_top #(
		.IMG_WIDTH   (IMG_WIDTH),
		.IMG_HEIGHT  (IMG_HEIGHT),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.DOWN_CREDITS(DOWN_CREDITS)
	) u_filter_top (
		.clk         (clk),
		.reset       (reset),
		.i_valid     (i_valid),
		.i_pixel     (i_pixel),
		.o_credit_ret(o_credit_ret),
		.o_valid     (o_valid),
		.o_pixel     (o_pixel),
		.o_last      (o_last),
		.i_credit    (i_credit)
	);

	always #10 clk = ~clk;

	function automatic int credits_held();
		return FIFO_DEPTH - credits_sent + credits_back;
	endfunction

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(string what, int got, int want);
		if (got != want) begin
			$display("[FAIL] time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, want);
			stop_with_failure();
		end
	endtask

	task automatic abort_on_timeout(string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		stop_with_failure();
	endtask

	// one pixel after an optional random gap and only while a credit is held
	task automatic send_pixel(conv_pkg::pixel_u pix);
		int gap;
		int waited;
		gap = (($urandom % 4) == 0) ? int'($urandom % 4) : 0;
		repeat (gap) begin
			@(posedge clk);
			i_valid <= 1'b0;
		end
		@(posedge clk);
		waited = 0;
		while (credits_held() == 0) begin
			i_valid <= 1'b0;
			waited++;
			if (waited > CREDIT_WAIT_LIMIT) begin
				abort_on_timeout("an upstream credit");
			end
			@(posedge clk);
		end
		i_valid <= 1'b1;
		i_pixel <= pix;
		credits_sent++;
		started = 1'b1;
	endtask

	// sink returns one credit per received pixel after random delays
	// stalls for a long stretch once the first frame is out
	always @(posedge clk) begin
		if (reset) begin
			i_credit <= 1'b0;
		end else if (stall_armed && stall_cnt < STALL_CYCLES) begin
			stall_cnt++;
			i_credit <= 1'b0;
		end else if (credits_given < out_count && ($urandom % 3) != 0) begin
			credits_given++;
			i_credit <= 1'b1;
		end else begin
			i_credit <= 1'b0;
		end
	end

	// monitor and scoreboard sample the outputs mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (!started) begin
				check_value("o_valid quiet before first pixel", int'(o_valid), 0);
				check_value("o_credit_ret quiet before first pixel", int'(o_credit_ret), 0);
			end
			credits_back += int'(o_credit_ret);
			check_value("upstream credits within 0..FIFO_DEPTH",
				int'(credits_held() >= 0 && credits_held() <= FIFO_DEPTH), 1);
			if (o_valid) begin
				check_value("output within expected total", int'(out_count < TOTAL_OUT), 1);
				check_value("outputs covered by downstream credits",
					int'(out_count + 1 <= DOWN_CREDITS + credit_pulses), 1);
				check_value("output pixel", int'(o_pixel.raw), int'(exp_pix[out_count].raw));
				check_value("output last flag", int'(o_last), int'(exp_last[out_count]));
				out_count++;
				if (out_count == FRAME_PIX) begin
					stall_armed = 1'b1;
				end
			end
			if (i_credit) begin
				credit_pulses++;
			end
		end
	end

	initial begin
		int waited;
		void'($urandom(32'h483e_bc16));
		reset = 1'b1;
		i_valid = 1'b0;
		i_pixel = '0;
		// stimulus frames and then the model's view of them in raster order
		for (int f = 0; f < NUM_FRAMES; f++) begin
			for (int row = 0; row < PAD_H; row++) begin
				for (int col = 0; col < PAD_W; col++) begin
					frames[f][row][col] = make_pixel(row, col);
				end
			end
			for (int y = 0; y < IMG_HEIGHT; y++) begin
				for (int x = 0; x < IMG_WIDTH; x++) begin
					exp_pix[f*FRAME_PIX + y*IMG_WIDTH + x] = expected_pixel(f, y, x);
					exp_last[f*FRAME_PIX + y*IMG_WIDTH + x] =
						(y == IMG_HEIGHT - 1) && (x == IMG_WIDTH - 1);
				end
			end
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		// outputs must stay quiet over an idle stretch
		repeat (20) @(posedge clk);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			for (int row = 0; row < PAD_H; row++) begin
				for (int col = 0; col < PAD_W; col++) begin
					send_pixel(frames[f][row][col]);
				end
			end
		end
		@(posedge clk);
		i_valid <= 1'b0;
		waited = 0;
		while (out_count < TOTAL_OUT) begin
			@(posedge clk);
			waited++;
			if (waited > DRAIN_LIMIT) begin
				abort_on_timeout("all output pixels");
			end
		end
		waited = 0;
		while (credits_held() != FIFO_DEPTH) begin
			@(posedge clk);
			waited++;
			if (waited > DRAIN_LIMIT) begin
				abort_on_timeout("all upstream credits to come back");
			end
		end
		// nothing more may leave after the last frame
		repeat (20) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule

/* list.f */
+incdir+dv
hw/conv_pkg.sv
hw/line_tap_buffer.sv
hw/channel_conv_3x3.sv
hw/pixel_filter.sv
hw/credit_out_fifo.sv
hw/filter_top.sv
dv/tb_filter_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then scan the run log for the failure line
verilator --binary --timing --assert --top-module tb_filter_top -f list.f -o sim_filter \
	&& { ./obj_dir/sim_filter > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& ! grep -q "Something failed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
